// File: hw/cmd_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module cmd_decoder #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  motion_pkg::spi_word_t rx_word,
  input  logic                  word_valid,
  output logic [63:0]           tx_word,
  input  logic signed [63:0]    count,
  input  logic                  enc_fault,
  output motion_pkg::move_t     move_head,
  output logic                  move_avail,
  input  logic                  move_pop,
  output logic                  enable,
  output logic [7:0]            clock_divisor,
  output logic                  BUFFER_DTR
);

  localparam int PTR_W = (MOVE_DEPTH > 1) ? $clog2(MOVE_DEPTH) : 1;
  localparam int OCC_W = $clog2(MOVE_DEPTH + 1);

  motion_pkg::move_t  queue [MOVE_DEPTH];
  motion_pkg::move_t  new_move;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [OCC_W-1:0]   occ;
  logic [2:0]         word_idx;     // 0 while waiting for a header
  logic               pend_dir;
  logic [63:0]        pend_dur;
  logic signed [63:0] pend_inc;
  logic signed [63:0] enc_snap;     // Count at the step header
  logic               fault_seen;
  logic               full;
  logic               push_req;
  logic               push;
  logic               pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(MOVE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full       = (occ == OCC_W'(MOVE_DEPTH));
  assign move_avail = (occ != '0);
  assign push_req   = word_valid && (word_idx == 3'd3);
  assign push       = push_req && !full;   // Dropped when full
  assign pop        = move_pop && move_avail;
  assign move_head  = queue[rd_ptr];

  always_comb begin
    new_move.dir       = pend_dir;
    new_move.duration  = pend_dur;
    new_move.increment = pend_inc;
    new_move.inc_inc   = rx_word.data;     // Third data word
  end

  // Message tracking, settings and reply word
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      word_idx      <= '0;
      enable        <= 1'b0;
      clock_divisor <= 8'd40;
      tx_word       <= '0;
      fault_seen    <= 1'b0;
    end else begin
      if (enc_fault)
        fault_seen <= 1'b1;
      if (word_valid) begin
        tx_word <= '0;
        if (word_idx == 3'd0) begin
          case (rx_word.hdr.cmd)
            motion_pkg::CMD_COORDINATED_STEP: word_idx <= 3'd1;
            motion_pkg::CMD_MOTOR_ENABLE:     enable <= rx_word.hdr.payload[0];
            motion_pkg::CMD_CLK_DIVISOR:      clock_divisor <= rx_word.hdr.payload[7:0];
            motion_pkg::CMD_API_VERSION: begin
              tx_word <= {fault_seen, 39'd0, motion_pkg::VERSION_MAJOR,
                          motion_pkg::VERSION_MINOR, motion_pkg::VERSION_PATCH};
            end
            default: ;                        // Unknown header ignored
          endcase
        end else if (word_idx == 3'd3) begin
          word_idx <= '0;
        end else begin
          word_idx <= word_idx + 3'd1;
          if (word_idx == 3'd2)
            tx_word <= enc_snap;              // Goes out during word 3
        end
      end
    end
  end

  // Move assembly and queue storage
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (word_idx)
        3'd0: begin
          if (rx_word.hdr.cmd == motion_pkg::CMD_COORDINATED_STEP) begin
            pend_dir <= rx_word.hdr.payload[0];
            enc_snap <= count;
          end
        end
        3'd1: pend_dur <= rx_word.data;
        3'd2: pend_inc <= rx_word.data;
        default: ;
      endcase
    end
    if (push)
      queue[wr_ptr] <= new_move;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      BUFFER_DTR <= 1'b1;
    end else begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: ;
      endcase
      BUFFER_DTR <= !full;                  // One cycle behind the queue
    end
  end

  a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n) push_req |-> !full)
    else $error("move queue full, move dropped");

  a_word_idx: assert property (@(posedge CLK) disable iff (!rst_n) word_idx <= 3'd3)
    else $error("word index out of range");

endmodule

`default_nettype wire

// File: hw/hbridge_phase.sv
`default_nettype none
`timescale 1ns/1ps

module hbridge_phase (
  input  logic CLK,
  input  logic rst_n,
  input  logic step,
  input  logic dir,
  input  logic enable,
  output logic PHASE_A1,
  output logic PHASE_A2,
  output logic PHASE_B1,
  output logic PHASE_B2
);

  logic [1:0] phase_idx;
  logic [3:0] coils;    // {A1, A2, B1, B2}

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      phase_idx <= '0;
    else if (step)
      phase_idx <= dir ? phase_idx + 2'd1 : phase_idx - 2'd1;
  end

  // Full-step sequence AB, A'B, A'B', AB'
  always_comb begin
    case (phase_idx)
      2'd0:    coils = 4'b1010;
      2'd1:    coils = 4'b0110;
      2'd2:    coils = 4'b0101;
      default: coils = 4'b1001;
    endcase
    if (!enable)
      coils = 4'b0000;  // Bridge off, index keeps tracking
  end

  assign {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2} = coils;

endmodule

`default_nettype wire

// File: hw/motion_pkg.sv
`default_nettype none

package motion_pkg;

  // Host command codes, top byte of a header word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE     = 8'h0A;
  localparam logic [7:0] CMD_CLK_DIVISOR      = 8'h0B;
  localparam logic [7:0] CMD_API_VERSION      = 8'hFE;

  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd3;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

  // 2^63 - 101, leaves headroom below the signed limit
  localparam logic signed [63:0] STEP_THRESHOLD = 64'sh7fff_ffff_ffff_ff9b;

  // Header view of an incoming word
  typedef struct packed {
    logic [7:0]  cmd;
    logic [55:0] payload;
  } spi_hdr_t;

  // Same 64 bits read as a header or as a raw data word
  typedef union packed {
    spi_hdr_t    hdr;
    logic [63:0] data;
  } spi_word_t;

  // One queued coordinated move
  typedef struct packed {
    logic               dir;
    logic [63:0]        duration;   // In ticks, move lasts duration+1
    logic signed [63:0] increment;
    logic signed [63:0] inc_inc;
  } move_t;

endpackage

`default_nettype wire

// File: hw/motion_top.sv
`default_nettype none
`timescale 1ns/1ps

module motion_top #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic CLK,
  input  logic rst_n,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic ENC_A,
  input  logic ENC_B,
  output logic PHASE_A1,
  output logic PHASE_A2,
  output logic PHASE_B1,
  output logic PHASE_B2,
  output logic BUFFER_DTR,
  output logic MOVE_DONE
);

  motion_pkg::spi_word_t rx_word;
  motion_pkg::move_t     move_head;
  logic [63:0]           tx_word;
  logic                  word_valid;
  logic signed [63:0]    count;
  logic                  enc_fault;
  logic                  move_avail;
  logic                  move_pop;
  logic                  enable;
  logic [7:0]            clock_divisor;
  logic                  step;
  logic                  dir;

  spi_word u_spi (
    .CLK(CLK), .rst_n(rst_n), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .tx_word(tx_word), .rx_word(rx_word), .word_valid(word_valid)
  );

  cmd_decoder #(.MOVE_DEPTH(MOVE_DEPTH)) u_cmd (
    .CLK(CLK), .rst_n(rst_n), .rx_word(rx_word), .word_valid(word_valid),
    .tx_word(tx_word), .count(count), .enc_fault(enc_fault),
    .move_head(move_head), .move_avail(move_avail), .move_pop(move_pop),
    .enable(enable), .clock_divisor(clock_divisor), .BUFFER_DTR(BUFFER_DTR)
  );

  step_dda u_dda (
    .CLK(CLK), .rst_n(rst_n), .move_head(move_head), .move_avail(move_avail),
    .clock_divisor(clock_divisor), .move_pop(move_pop), .step(step), .dir(dir),
    .MOVE_DONE(MOVE_DONE)
  );

  quad_enc u_enc (
    .CLK(CLK), .rst_n(rst_n), .ENC_A(ENC_A), .ENC_B(ENC_B),
    .count(count), .enc_fault(enc_fault)
  );

  hbridge_phase u_phase (
    .CLK(CLK), .rst_n(rst_n), .step(step), .dir(dir), .enable(enable),
    .PHASE_A1(PHASE_A1), .PHASE_A2(PHASE_A2), .PHASE_B1(PHASE_B1), .PHASE_B2(PHASE_B2)
  );

endmodule

`default_nettype wire

// File: hw/quad_enc.sv
`default_nettype none
`timescale 1ns/1ps

module quad_enc (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               ENC_A,
  input  logic               ENC_B,
  output logic signed [63:0] count,
  output logic               enc_fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_prev;
  logic       b_prev;
  logic       a_chg;
  logic       b_chg;
  logic       up;

  assign a_chg = a_sync[1] ^ a_prev;
  assign b_chg = b_sync[1] ^ b_prev;
  // New A against old B gives the direction for either edge
  assign up    = a_sync[1] ^ b_prev;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      a_sync    <= '0;
      b_sync    <= '0;
      a_prev    <= 1'b0;
      b_prev    <= 1'b0;
      count     <= '0;
      enc_fault <= 1'b0;
    end else begin
      a_sync    <= {a_sync[0], ENC_A};
      b_sync    <= {b_sync[0], ENC_B};
      a_prev    <= a_sync[1];
      b_prev    <= b_sync[1];
      enc_fault <= a_chg & b_chg;         // Skipped Gray state
      if (a_chg ^ b_chg) begin
        if (up)
          count <= count + 64'sd1;
        else
          count <= count - 64'sd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_word.sv
`default_nettype none
`timescale 1ns/1ps

module spi_word (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  SCK,
  input  logic                  CS,
  input  logic                  COPI,
  output logic                  CIPO,
  input  logic [63:0]           tx_word,
  output motion_pkg::spi_word_t rx_word,
  output logic                  word_valid
);

  logic [2:0]  sck_q;
  logic [2:0]  cs_q;
  logic [2:0]  copi_q;
  logic        sck_rise;   // Registered edge detects
  logic        sck_fall;
  logic        cs_fall;
  logic [5:0]  bit_cnt;
  logic [63:0] rx_shift;
  logic [63:0] tx_shift;
  logic        tx_load;    // Reload reply once the decoder has updated it

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sck_q    <= '0;
      cs_q     <= '1;
      copi_q   <= '0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      cs_fall  <= 1'b0;
    end else begin
      sck_q    <= {sck_q[1:0], SCK};
      cs_q     <= {cs_q[1:0], CS};
      copi_q   <= {copi_q[1:0], COPI};
      sck_rise <= sck_q[1] & ~sck_q[2];
      sck_fall <= ~sck_q[1] & sck_q[2];
      cs_fall  <= ~cs_q[1] & cs_q[2];
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
      tx_load    <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      tx_load    <= word_valid;
      if (cs_q[2]) begin
        bit_cnt <= '0;                       // Deselected, realign to word start
      end else if (sck_rise) begin
        bit_cnt    <= bit_cnt + 6'd1;        // Wraps after 64 bits
        word_valid <= (bit_cnt == 6'd63);
      end
    end
  end

  // Shift registers, MSB first in both directions
  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_q[2]) begin
      rx_shift <= {rx_shift[62:0], copi_q[2]};
      if (bit_cnt == 6'd63)
        rx_word.data <= {rx_shift[62:0], copi_q[2]};
    end
    if (cs_fall || tx_load)
      tx_shift <= tx_word;
    else if (sck_fall && bit_cnt != 6'd0)    // Hold bit 63 until first rising edge
      tx_shift <= {tx_shift[62:0], 1'b0};
  end

  assign CIPO = tx_shift[63];

endmodule

`default_nettype wire

// File: hw/step_dda.sv
`default_nettype none
`timescale 1ns/1ps

module step_dda (
  input  logic              CLK,
  input  logic              rst_n,
  input  motion_pkg::move_t move_head,
  input  logic              move_avail,
  input  logic [7:0]        clock_divisor,
  output logic              move_pop,
  output logic              step,
  output logic              dir,
  output logic              MOVE_DONE
);

  logic               busy;
  logic [7:0]         prescale;     // Counts down to the next tick
  logic [63:0]        ticks_left;
  logic signed [63:0] incr;
  logic signed [63:0] inc_inc;
  logic signed [63:0] acc;          // Substep accumulator, kept across moves
  logic signed [63:0] acc_next;
  logic               tick;

  assign move_pop = !busy && move_avail;
  assign tick     = busy && (prescale == 8'd0);
  assign step     = (acc > 0);

  // Rollback and tick add can land in the same cycle
  always_comb begin
    acc_next = acc;
    if (step)
      acc_next = acc_next - motion_pkg::STEP_THRESHOLD;
    if (tick)
      acc_next = acc_next + incr;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      prescale   <= '0;
      ticks_left <= '0;
      acc        <= '0;
      dir        <= 1'b0;
      MOVE_DONE  <= 1'b0;
    end else begin
      acc <= acc_next;
      if (move_pop) begin
        busy       <= 1'b1;
        prescale   <= clock_divisor;
        ticks_left <= move_head.duration;
        dir        <= move_head.dir;
      end else if (busy) begin
        if (tick) begin
          prescale   <= clock_divisor;
          ticks_left <= ticks_left - 64'd1;
          if (ticks_left == 64'd0) begin
            busy      <= 1'b0;            // Next move loads after this
            MOVE_DONE <= ~MOVE_DONE;
          end
        end else begin
          prescale <= prescale - 8'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (move_pop) begin
      incr    <= move_head.increment;
      inc_inc <= move_head.inc_inc;
    end else if (tick) begin
      incr <= incr + inc_inc;
    end
  end

  a_pop_valid: assert property (@(posedge CLK) disable iff (!rst_n) move_pop |-> move_avail)
    else $error("move popped from empty queue");

endmodule

`default_nettype wire

// File: motion_top.f
hw/motion_pkg.sv
hw/spi_word.sv
hw/cmd_decoder.sv
hw/step_dda.sv
hw/quad_enc.sv
hw/hbridge_phase.sv
hw/motion_top.sv
tb/tb_motion_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_motion_top \
  -f motion_top.f -o sim_motion_top
./obj_dir/sim_motion_top > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  exit 1
fi

// File: tb/tb_motion_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_motion_top;

  localparam int MOVE_DEPTH = 4;
  localparam int MAX_CYCLES = 200000;  // About twice the longest expected run
  localparam logic signed [63:0] THRESH = 64'sh7fff_ffff_ffff_ff9b;  // 2^63 - 101

  logic CLK;
  logic rst_n;
  logic SCK;
  logic CS;
  logic COPI;
  logic CIPO;
  logic ENC_A;
  logic ENC_B;
  logic PHASE_A1;
  logic PHASE_A2;
  logic PHASE_B1;
  logic PHASE_B2;
  logic BUFFER_DTR;
  logic MOVE_DONE;

  int                 n_errors;
  int                 n_checks;
  int                 cycles;
  int                 phase_pos;    // Net full steps seen on the coils
  int                 last_idx;
  int                 mon_idx;
  int                 mon_delta;
  logic               done_seen;    // Last MOVE_DONE level already accounted for
  logic signed [63:0] ref_acc;      // Model accumulator, kept across moves
  logic signed [63:0] enc_pos;

  motion_top #(.MOVE_DEPTH(MOVE_DEPTH)) u_dut (
    .CLK(CLK), .rst_n(rst_n), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .ENC_A(ENC_A), .ENC_B(ENC_B),
    .PHASE_A1(PHASE_A1), .PHASE_A2(PHASE_A2), .PHASE_B1(PHASE_B1), .PHASE_B2(PHASE_B2),
    .BUFFER_DTR(BUFFER_DTR), .MOVE_DONE(MOVE_DONE)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a move or transfer never completed", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic int phase_index(input logic [3:0] coils);
    case (coils)
      4'b1010: return 0;
      4'b0110: return 1;
      4'b0101: return 2;
      4'b1001: return 3;
      default: return -1;   // Bridge off
    endcase
  endfunction

  // Coil monitor, one full step per state change
  always @(negedge CLK) begin
    mon_idx = phase_index({PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2});
    if (rst_n && mon_idx >= 0 && mon_idx != last_idx) begin
      mon_delta = (mon_idx - last_idx) & 3;
      assert (mon_delta != 2) else begin
        n_errors++;
        $display("Coil sequence skipped a full-step state at %0t", $time);
      end
      if (mon_delta == 1)
        phase_pos++;
      else if (mon_delta == 3)
        phase_pos--;
      last_idx = mon_idx;
    end
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge CLK);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got == exp) else begin
      n_errors++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One 64-bit word, CS framed, 8 CLK per SCK half period
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    int i;
    @(posedge CLK);
    CS <= 1'b0;
    for (i = 63; i >= 0; i--) begin
      COPI <= tx[i];
      wait_clks(8);
      @(negedge CLK);
      rx[i] = CIPO;     // Stable since the last falling SCK
      @(posedge CLK);
      SCK <= 1'b1;
      wait_clks(8);
      SCK <= 1'b0;
    end
    wait_clks(8);
    CS   <= 1'b1;
    COPI <= 1'b0;
    wait_clks(8);
  endtask

  task automatic send_cmd(input logic [7:0] cmd, input logic [55:0] payload);
    logic [63:0] rx;
    spi_xfer({cmd, payload}, rx);
  endtask

  task automatic send_move(input logic dir, input logic [63:0] dur,
                           input logic signed [63:0] inc, input logic signed [63:0] inc_inc,
                           output logic [63:0] reply);
    logic [63:0] rx;
    spi_xfer({motion_pkg::CMD_COORDINATED_STEP, 55'd0, dir}, rx);
    spi_xfer(dur, rx);
    spi_xfer(inc, rx);
    spi_xfer(inc_inc, reply);   // Carries the encoder snapshot
  endtask

  // Tick level DDA model, steps drain between ticks
  task automatic dda_model(input logic [63:0] dur, input logic signed [63:0] inc,
                           input logic signed [63:0] inc_inc, output int steps);
    logic signed [63:0] cur;
    logic [63:0]        t;
    steps = 0;
    cur   = inc;
    for (t = 0; t <= dur; t++) begin
      ref_acc = ref_acc + cur;
      cur     = cur + inc_inc;
      while (ref_acc > 0) begin
        steps++;
        ref_acc = ref_acc - THRESH;
      end
    end
  endtask

  task automatic enc_edge(input logic a, input logic b);
    @(posedge CLK);
    ENC_A <= a;
    ENC_B <= b;
    wait_clks(6);
  endtask

  task automatic quad_cycle(input logic fwd);
    if (fwd) begin
      enc_edge(1'b1, 1'b0);   // A leads
      enc_edge(1'b1, 1'b1);
      enc_edge(1'b0, 1'b1);
      enc_edge(1'b0, 1'b0);
      enc_pos = enc_pos + 64'sd4;
    end else begin
      enc_edge(1'b0, 1'b1);   // B leads
      enc_edge(1'b1, 1'b1);
      enc_edge(1'b1, 1'b0);
      enc_edge(1'b0, 1'b0);
      enc_pos = enc_pos - 64'sd4;
    end
  endtask

  // Returns a few cycles after the toggle so trailing steps are counted
  task automatic wait_move_done();
    @(negedge CLK);
    while (MOVE_DONE == done_seen)
      @(negedge CLK);
    done_seen = MOVE_DONE;
    wait_clks(4);
  endtask

  task automatic test_reset_version();
    logic [63:0] rx;
    @(negedge CLK);
    check_val("PHASE_A1..B2", {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2}, 4'b0000);
    check_val("BUFFER_DTR", BUFFER_DTR, 1'b1);
    check_val("MOVE_DONE", MOVE_DONE, 1'b0);
    send_cmd(motion_pkg::CMD_API_VERSION, 56'd0);
    spi_xfer(64'd0, rx);
    check_val("version reply[23:0]", rx[23:0], 24'h000301);
    check_val("encoder fault flag", rx[63], 1'b0);
  endtask

  task automatic test_encoder();
    int          n_cyc;
    int          k;
    logic [63:0] rx;
    n_cyc = $urandom_range(40, 8);
    for (k = 0; k < n_cyc; k++)
      quad_cycle($urandom_range(1, 0) == 1);
    wait_clks(10);
    send_move(1'b0, 64'd0, 64'sd0, 64'sd0, rx);
    check_val("encoder snapshot", rx, enc_pos);
    wait_move_done();
  endtask

  task automatic test_enable();
    send_cmd(motion_pkg::CMD_MOTOR_ENABLE, 56'd1);
    @(negedge CLK);
    check_val("PHASE_A1..B2 enabled", {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2}, 4'b1010);
    send_cmd(motion_pkg::CMD_MOTOR_ENABLE, 56'd0);
    @(negedge CLK);
    check_val("PHASE_A1..B2 disabled", {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2}, 4'b0000);
  endtask

  task automatic test_single_move();
    int          steps;
    int          start;
    logic [63:0] rx;
    send_cmd(motion_pkg::CMD_CLK_DIVISOR, 56'd3);
    send_cmd(motion_pkg::CMD_MOTOR_ENABLE, 56'd1);
    dda_model(64'd20, 64'sh2000_0000_0000_0000, 64'sh0200_0000_0000_0000, steps);
    start = phase_pos;
    send_move(1'b1, 64'd20, 64'sh2000_0000_0000_0000, 64'sh0200_0000_0000_0000, rx);
    wait_move_done();
    check_val("net phase, single move", phase_pos - start, steps);
  endtask

  task automatic test_queue();
    int                 move_steps [MOVE_DEPTH+1];
    int                 start;
    int                 k;
    logic signed [63:0] inc;
    logic [63:0]        rx;
    // One move runs while MOVE_DEPTH more fill the queue
    for (k = 0; k <= MOVE_DEPTH; k++) begin
      inc = 64'(k + 1) << 56;
      dda_model(64'd4999, inc, 64'sh0000_0010_0000_0000, move_steps[k]);
      if (k == MOVE_DEPTH) begin
        @(negedge CLK);
        check_val("BUFFER_DTR before last push", BUFFER_DTR, 1'b1);
      end
      if (k == 0)
        start = phase_pos;
      send_move(k[0], 64'd4999, inc, 64'sh0000_0010_0000_0000, rx);
    end
    @(negedge CLK);
    check_val("BUFFER_DTR with full queue", BUFFER_DTR, 1'b0);
    for (k = 0; k <= MOVE_DEPTH; k++) begin
      wait_move_done();
      check_val($sformatf("net phase, move %0d", k), phase_pos - start,
                k[0] ? move_steps[k] : -move_steps[k]);
      start = phase_pos;
      if (k == 0) begin
        @(negedge CLK);
        check_val("BUFFER_DTR after first pop", BUFFER_DTR, 1'b1);
      end
    end
    @(negedge CLK);
    check_val("BUFFER_DTR after drain", BUFFER_DTR, 1'b1);
  endtask

  initial begin
    rst_n     = 1'b0;
    SCK       = 1'b0;
    CS        = 1'b1;
    COPI      = 1'b0;
    ENC_A     = 1'b0;
    ENC_B     = 1'b0;
    n_errors  = 0;
    n_checks  = 0;
    cycles    = 0;
    phase_pos = 0;
    last_idx  = 0;
    done_seen = 1'b0;
    ref_acc   = '0;
    enc_pos   = '0;
    void'($urandom(32'heaf0_df01));
    wait_clks(2);
    rst_n <= 1'b1;
    wait_clks(2);

    test_reset_version();
    test_encoder();
    test_enable();
    test_single_move();
    test_queue();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
